/* source/commit_pkg.sv */
`default_nettype none

package commit_pkg;

    localparam int ISSUE_WIDTH    = 2;
    localparam int PIPE_WIDTH     = 8;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int CSR_ADDR_WIDTH = 14;

    // pc of an empty slot
    localparam logic [31:0] RESET_PC = 32'h1c00_0000;

    localparam logic [CSR_ADDR_WIDTH-1:0] CSR_CRMD   = 14'h0;
    localparam logic [CSR_ADDR_WIDTH-1:0] CSR_PRMD   = 14'h1;
    localparam logic [CSR_ADDR_WIDTH-1:0] CSR_ECFG   = 14'h4;
    localparam logic [CSR_ADDR_WIDTH-1:0] CSR_ESTAT  = 14'h5;
    localparam logic [CSR_ADDR_WIDTH-1:0] CSR_ERA    = 14'h6;
    localparam logic [CSR_ADDR_WIDTH-1:0] CSR_BADV   = 14'h7;
    localparam logic [CSR_ADDR_WIDTH-1:0] CSR_EENTRY = 14'hc;

    typedef enum logic [4:0] {
        NOP, INT, PIL, PIS, PIF, PME, PPI, ADEF, ADEM,
        ALE, SYS, BRK, INE, IPE, FPD, FPE, TLBR
    } excp_t;

    typedef enum logic [1:0] {
        OP_NORMAL,
        OP_ERTN,
        OP_IDLE
    } commit_op_t;

    typedef struct packed {
        logic [31:0]  pc;
        commit_op_t   op;
        logic         is_privilege;
        // one flag and one cause per stage
        logic [5:0]   is_exception;
        excp_t [5:0]  exception_cause;
        logic [31:0]  mem_addr;
    } commit_t;

    typedef struct packed {
        logic                      reg_write_en;
        logic [REG_ADDR_WIDTH-1:0] reg_write_addr;
        logic [31:0]               reg_write_data;
        logic                      csr_write_en;
        logic [CSR_ADDR_WIDTH-1:0] csr_write_addr;
        logic [31:0]               csr_write_data;
        logic                      is_llw_scw;
    } wb_t;

    typedef struct packed {
        logic pause_if;
        logic pause_icache;
        logic pause_buffer;
        logic pause_decoder;
        logic pause_dispatch;
        logic pause_execute;
        logic pause_mem;
    } pause_req_t;

    typedef struct packed {
        logic [1:0]  plv;
        logic        ie;
        logic [11:0] lie;
        logic [11:0] is;
        logic [31:0] era;
        logic [31:0] eentry;
    } csr_state_t;

    typedef struct packed {
        logic                      excp_valid;
        logic                      ertn_valid;
        logic [5:0]                ecode;
        logic [8:0]                esubcode;
        logic [31:0]               excp_pc;
        logic                      badv_valid;
        logic [31:0]               badv;
        logic                      wr_en;
        logic [CSR_ADDR_WIDTH-1:0] wr_addr;
        logic [31:0]               wr_data;
    } csr_cmd_t;

    // returns {ecode, esubcode}
    function automatic logic [14:0] ecode_of(input excp_t cause);
        case (cause)
            INT:     return {6'h00, 9'd0};
            PIL:     return {6'h01, 9'd0};
            PIS:     return {6'h02, 9'd0};
            PIF:     return {6'h03, 9'd0};
            PME:     return {6'h04, 9'd0};
            PPI:     return {6'h07, 9'd0};
            ADEF:    return {6'h08, 9'd0};
            ADEM:    return {6'h08, 9'd1};
            ALE:     return {6'h09, 9'd0};
            SYS:     return {6'h0b, 9'd0};
            BRK:     return {6'h0c, 9'd0};
            INE:     return {6'h0d, 9'd0};
            IPE:     return {6'h0e, 9'd0};
            FPD:     return {6'h0f, 9'd0};
            FPE:     return {6'h12, 9'd0};
            TLBR:    return {6'h3f, 9'd0};
            default: return {6'h00, 9'd0};
        endcase
    endfunction

endpackage

`default_nettype wire

/* source/commit_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module commit_ctrl (
    input  wire commit_pkg::commit_t [commit_pkg::ISSUE_WIDTH-1:0] commit_i,
    input  wire commit_pkg::wb_t [commit_pkg::ISSUE_WIDTH-1:0]     wb_i,
    input  wire commit_pkg::pause_req_t                           pause_req_i,
    input  wire logic                                             branch_flush_i,
    input  wire logic [31:0]                                      branch_target_i,
    input  wire logic                                             ex_excp_flush_i,
    input  wire logic                                             bpu_flush_i,
    input  wire commit_pkg::csr_state_t                           csr_state_i,
    output logic [commit_pkg::PIPE_WIDTH-1:0]                     flush_o,
    output logic [commit_pkg::PIPE_WIDTH-1:0]                     pause_o,
    output logic [31:0]                                           new_pc_o,
    output logic                                                  is_interrupt_o,
    output logic                                                  is_llw_scw_o,
    output commit_pkg::csr_cmd_t                                  csr_cmd_o,
    output logic [commit_pkg::ISSUE_WIDTH-1:0]                    rf_we_o,
    output logic [commit_pkg::ISSUE_WIDTH-1:0][commit_pkg::REG_ADDR_WIDTH-1:0] rf_waddr_o,
    output logic [commit_pkg::ISSUE_WIDTH-1:0][31:0]              rf_wdata_o
);

    logic [11:0]                          int_vec;
    logic [commit_pkg::ISSUE_WIDTH-1:0]   excp;
    logic [commit_pkg::ISSUE_WIDTH-1:0]   ertn_slot;
    logic [commit_pkg::ISSUE_WIDTH-1:0]   we_pre;
    commit_pkg::excp_t [commit_pkg::ISSUE_WIDTH-1:0] cause;
    commit_pkg::excp_t                    cause_sel;
    logic                                 any_excp;
    logic                                 ertn_valid;
    logic                                 redirect;
    logic                                 pause_idle;
    logic [3:0]                           pause_back;
    logic [2:0]                           pause_front;

    // pending and enabled interrupts, masked by global ie
    assign int_vec        = csr_state_i.ie ? (csr_state_i.lie & csr_state_i.is) : 12'b0;
    assign is_interrupt_o = (int_vec != 12'b0);

    for (genvar i = 0; i < commit_pkg::ISSUE_WIDTH; i++) begin : g_slot
        assign excp[i] = commit_i[i].pc != 32'b0 && commit_i[i].pc != commit_pkg::RESET_PC
                         && (commit_i[i].is_exception != 6'b0 || is_interrupt_o);
        assign ertn_slot[i] = commit_i[i].is_exception == 6'b0
                              && commit_i[i].op == commit_pkg::OP_ERTN;
        assign rf_waddr_o[i] = wb_i[i].reg_write_addr;
        assign rf_wdata_o[i] = wb_i[i].reg_write_data;
    end

    assign any_excp   = |excp;
    assign ertn_valid = |ertn_slot && !any_excp;
    assign redirect   = any_excp || ertn_valid;

    // later stages override earlier ones
    always_comb begin
        for (int i = 0; i < commit_pkg::ISSUE_WIDTH; i++) begin
            cause[i] = commit_pkg::NOP;
            for (int s = 0; s < 6; s++) begin
                if (commit_i[i].is_exception[s]) begin
                    cause[i] = commit_i[i].exception_cause[s];
                    if (s == 2 && commit_i[i].is_privilege && csr_state_i.plv != 2'b00) begin
                        cause[i] = commit_pkg::IPE;
                    end
                end
            end
            if (is_interrupt_o) begin
                cause[i] = commit_pkg::INT;
            end
            if (!excp[i]) begin
                cause[i] = commit_pkg::NOP;
            end
        end
    end

    assign cause_sel = excp[0] ? cause[0] : cause[1];

    always_comb begin
        csr_cmd_o                      = '0;
        csr_cmd_o.excp_valid           = any_excp;
        csr_cmd_o.ertn_valid           = ertn_valid;
        {csr_cmd_o.ecode, csr_cmd_o.esubcode} = commit_pkg::ecode_of(cause_sel);
        csr_cmd_o.excp_pc              = excp[0] ? commit_i[0].pc : commit_i[1].pc;
        csr_cmd_o.badv                 = excp[0] ? commit_i[0].mem_addr : commit_i[1].mem_addr;
        csr_cmd_o.badv_valid           = any_excp && (cause_sel inside {
            commit_pkg::ADEF, commit_pkg::ADEM, commit_pkg::ALE, commit_pkg::PIL,
            commit_pkg::PIS, commit_pkg::PIF, commit_pkg::PME, commit_pkg::PPI});
        // first slot with a csr write wins
        csr_cmd_o.wr_en   = (wb_i[0].csr_write_en || wb_i[1].csr_write_en) && !any_excp;
        csr_cmd_o.wr_addr = wb_i[0].csr_write_en ? wb_i[0].csr_write_addr
                                                 : wb_i[1].csr_write_addr;
        csr_cmd_o.wr_data = wb_i[0].csr_write_en ? wb_i[0].csr_write_data
                                                 : wb_i[1].csr_write_data;
    end

    assign new_pc_o = any_excp ? csr_state_i.eentry
                    : (ertn_valid ? csr_state_i.era : branch_target_i);

    // 0 pc, 1 icache, 2 instbuffer, 3 id, 4 dispatch, 5 ex, 6 mem, 7 wb
    assign flush_o = {
        1'b0,
        redirect,
        redirect,
        redirect || branch_flush_i || ex_excp_flush_i,
        redirect || branch_flush_i || ex_excp_flush_i,
        redirect || branch_flush_i,
        redirect || branch_flush_i || bpu_flush_i,
        redirect || branch_flush_i
    };

    assign pause_idle = (commit_i[0].op == commit_pkg::OP_IDLE
                         || commit_i[1].op == commit_pkg::OP_IDLE) && !is_interrupt_o;

    always_comb begin
        if (pause_req_i.pause_mem || pause_idle) begin
            pause_back = 4'b1111;
        end else if (pause_req_i.pause_execute) begin
            pause_back = 4'b0111;
        end else if (pause_req_i.pause_dispatch) begin
            pause_back = 4'b0011;
        end else if (pause_req_i.pause_decoder) begin
            pause_back = 4'b0001;
        end else begin
            pause_back = 4'b0000;
        end

        if (pause_req_i.pause_buffer) begin
            pause_front = 3'b111;
        end else if (pause_req_i.pause_icache) begin
            pause_front = 3'b011;
        end else if (pause_req_i.pause_if) begin
            pause_front = 3'b001;
        end else begin
            pause_front = 3'b000;
        end
    end

    assign pause_o = {1'b0, pause_back, pause_front};

    assign we_pre[0] = wb_i[0].reg_write_en && !excp[0] && !pause_o[7];
    assign we_pre[1] = wb_i[1].reg_write_en && !any_excp && !pause_o[7];

    // younger slot wins a same-address pair
    assign rf_we_o[0] = we_pre[0] && !(we_pre[1] && rf_waddr_o[0] == rf_waddr_o[1]);
    assign rf_we_o[1] = we_pre[1];

    assign is_llw_scw_o = wb_i[0].is_llw_scw || wb_i[1].is_llw_scw;

endmodule

`default_nettype wire

/* source/csr_file.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_file (
    input  wire logic                                 clk,
    input  wire logic                                 rst_i,
    input  wire commit_pkg::csr_cmd_t                 csr_cmd_i,
    input  wire logic [7:0]                           hw_int_i,
    input  wire logic [commit_pkg::CSR_ADDR_WIDTH-1:0] raddr_i,
    output logic [31:0]                               rdata_o,
    output commit_pkg::csr_state_t                    csr_state_o
);

    logic [1:0]  crmd_plv;
    logic        crmd_ie;
    logic [1:0]  prmd_pplv;
    logic        prmd_pie;
    logic [12:0] ecfg_lie;
    logic [1:0]  estat_is_sw;
    logic [7:0]  estat_is_hw;
    logic [5:0]  estat_ecode;
    logic [8:0]  estat_esubcode;
    logic [31:0] era;
    logic [31:0] badv;
    logic [25:0] eentry_hi;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            crmd_plv       <= 2'b0;
            crmd_ie        <= 1'b0;
            prmd_pplv      <= 2'b0;
            prmd_pie       <= 1'b0;
            ecfg_lie       <= 13'b0;
            estat_is_sw    <= 2'b0;
            estat_is_hw    <= 8'b0;
            estat_ecode    <= 6'b0;
            estat_esubcode <= 9'b0;
            era            <= 32'b0;
            badv           <= 32'b0;
            eentry_hi      <= 26'b0;
        end else begin
            estat_is_hw <= hw_int_i;
            if (csr_cmd_i.excp_valid) begin
                prmd_pplv      <= crmd_plv;
                prmd_pie       <= crmd_ie;
                crmd_plv       <= 2'b0;
                crmd_ie        <= 1'b0;
                era            <= csr_cmd_i.excp_pc;
                estat_ecode    <= csr_cmd_i.ecode;
                estat_esubcode <= csr_cmd_i.esubcode;
                if (csr_cmd_i.badv_valid) begin
                    badv <= csr_cmd_i.badv;
                end
            end else if (csr_cmd_i.ertn_valid) begin
                crmd_plv <= prmd_pplv;
                crmd_ie  <= prmd_pie;
            end else if (csr_cmd_i.wr_en) begin
                case (csr_cmd_i.wr_addr)
                    commit_pkg::CSR_CRMD: begin
                        crmd_plv <= csr_cmd_i.wr_data[1:0];
                        crmd_ie  <= csr_cmd_i.wr_data[2];
                    end
                    commit_pkg::CSR_PRMD: begin
                        prmd_pplv <= csr_cmd_i.wr_data[1:0];
                        prmd_pie  <= csr_cmd_i.wr_data[2];
                    end
                    // bit 10 is reserved
                    commit_pkg::CSR_ECFG:   ecfg_lie    <= csr_cmd_i.wr_data[12:0] & 13'h1bff;
                    // only the two software interrupt bits are writable
                    commit_pkg::CSR_ESTAT:  estat_is_sw <= csr_cmd_i.wr_data[1:0];
                    commit_pkg::CSR_ERA:    era         <= csr_cmd_i.wr_data;
                    commit_pkg::CSR_BADV:   badv        <= csr_cmd_i.wr_data;
                    commit_pkg::CSR_EENTRY: eentry_hi   <= csr_cmd_i.wr_data[31:6];
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (raddr_i)
            commit_pkg::CSR_CRMD:   rdata_o = {29'b0, crmd_ie, crmd_plv};
            commit_pkg::CSR_PRMD:   rdata_o = {29'b0, prmd_pie, prmd_pplv};
            commit_pkg::CSR_ECFG:   rdata_o = {19'b0, ecfg_lie};
            commit_pkg::CSR_ESTAT:  rdata_o = {1'b0, estat_esubcode, estat_ecode, 6'b0,
                                               estat_is_hw, estat_is_sw};
            commit_pkg::CSR_ERA:    rdata_o = era;
            commit_pkg::CSR_BADV:   rdata_o = badv;
            commit_pkg::CSR_EENTRY: rdata_o = {eentry_hi, 6'b0};
            default:                rdata_o = 32'b0;
        endcase
    end

    // timer and ipi pending bits stay zero
    assign csr_state_o.plv    = crmd_plv;
    assign csr_state_o.ie     = crmd_ie;
    assign csr_state_o.lie    = {ecfg_lie[12:11], ecfg_lie[9:0]};
    assign csr_state_o.is     = {2'b00, estat_is_hw, estat_is_sw};
    assign csr_state_o.era    = era;
    assign csr_state_o.eentry = {eentry_hi, 6'b0};

    // controller never enters and returns in one cycle
    assert property (@(posedge clk) disable iff (rst_i)
        !(csr_cmd_i.excp_valid && csr_cmd_i.ertn_valid));

endmodule

`default_nettype wire

/* source/arch_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module arch_regfile (
    input  wire logic                                 clk,
    input  wire logic [commit_pkg::ISSUE_WIDTH-1:0]   we_i,
    input  wire logic [commit_pkg::ISSUE_WIDTH-1:0][commit_pkg::REG_ADDR_WIDTH-1:0] waddr_i,
    input  wire logic [commit_pkg::ISSUE_WIDTH-1:0][31:0] wdata_i,
    input  wire logic [commit_pkg::REG_ADDR_WIDTH-1:0] raddr_i,
    output logic [31:0]                               rdata_o
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        for (int i = 0; i < commit_pkg::ISSUE_WIDTH; i++) begin
            if (we_i[i] && waddr_i[i] != '0) begin
                regs[waddr_i[i]] <= wdata_i[i];
            end
        end
    end

    // r0 is never written, so mask it on read
    assign rdata_o = (raddr_i == '0) ? 32'b0 : regs[raddr_i];

    // the commit controller resolves same-address pairs upstream
    assert property (@(posedge clk)
        !(we_i[0] && we_i[1] && waddr_i[0] == waddr_i[1]));

endmodule

`default_nettype wire

/* source/commit_top.sv */
`timescale 1ns/1ps
`default_nettype none

module commit_top (
    input  wire logic                                  clk,
    input  wire logic                                  rst_i,
    input  wire commit_pkg::commit_t [commit_pkg::ISSUE_WIDTH-1:0] commit_i,
    input  wire commit_pkg::wb_t [commit_pkg::ISSUE_WIDTH-1:0]     wb_i,
    input  wire commit_pkg::pause_req_t                pause_req_i,
    input  wire logic                                  branch_flush_i,
    input  wire logic [31:0]                           branch_target_i,
    input  wire logic                                  ex_excp_flush_i,
    input  wire logic                                  bpu_flush_i,
    input  wire logic [7:0]                            hw_int_i,
    input  wire logic [commit_pkg::REG_ADDR_WIDTH-1:0] rf_raddr_i,
    input  wire logic [commit_pkg::CSR_ADDR_WIDTH-1:0] csr_raddr_i,
    output logic [31:0]                                rf_rdata_o,
    output logic [31:0]                                csr_rdata_o,
    output logic [commit_pkg::PIPE_WIDTH-1:0]          flush_o,
    output logic [commit_pkg::PIPE_WIDTH-1:0]          pause_o,
    output logic [31:0]                                new_pc_o,
    output logic                                       is_interrupt_o,
    output logic                                       is_llw_scw_o
);

    commit_pkg::csr_state_t                    csr_state;
    commit_pkg::csr_cmd_t                      csr_cmd;
    logic [commit_pkg::ISSUE_WIDTH-1:0]        rf_we;
    logic [commit_pkg::ISSUE_WIDTH-1:0][commit_pkg::REG_ADDR_WIDTH-1:0] rf_waddr;
    logic [commit_pkg::ISSUE_WIDTH-1:0][31:0]  rf_wdata;

    commit_ctrl u_commit_ctrl (
        .commit_i        (commit_i),
        .wb_i            (wb_i),
        .pause_req_i     (pause_req_i),
        .branch_flush_i  (branch_flush_i),
        .branch_target_i (branch_target_i),
        .ex_excp_flush_i (ex_excp_flush_i),
        .bpu_flush_i     (bpu_flush_i),
        .csr_state_i     (csr_state),
        .flush_o         (flush_o),
        .pause_o         (pause_o),
        .new_pc_o        (new_pc_o),
        .is_interrupt_o  (is_interrupt_o),
        .is_llw_scw_o    (is_llw_scw_o),
        .csr_cmd_o       (csr_cmd),
        .rf_we_o         (rf_we),
        .rf_waddr_o      (rf_waddr),
        .rf_wdata_o      (rf_wdata)
    );

    csr_file u_csr_file (
        .clk         (clk),
        .rst_i       (rst_i),
        .csr_cmd_i   (csr_cmd),
        .hw_int_i    (hw_int_i),
        .raddr_i     (csr_raddr_i),
        .rdata_o     (csr_rdata_o),
        .csr_state_o (csr_state)
    );

    arch_regfile u_arch_regfile (
        .clk     (clk),
        .we_i    (rf_we),
        .waddr_i (rf_waddr),
        .wdata_i (rf_wdata),
        .raddr_i (rf_raddr_i),
        .rdata_o (rf_rdata_o)
    );

endmodule

`default_nettype wire

/* testbench/commit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module commit_tb;

    logic                                               clk;
    logic                                               rst_i;
    commit_pkg::commit_t [commit_pkg::ISSUE_WIDTH-1:0]  commit;
    commit_pkg::wb_t [commit_pkg::ISSUE_WIDTH-1:0]      wb;
    commit_pkg::pause_req_t                             pause_req;
    logic                                               branch_flush;
    logic [31:0]                                        branch_target;
    logic                                               ex_excp_flush;
    logic                                               bpu_flush;
    logic [7:0]                                         hw_int;
    logic [commit_pkg::REG_ADDR_WIDTH-1:0]              rf_raddr;
    logic [commit_pkg::CSR_ADDR_WIDTH-1:0]              csr_raddr;
    logic [31:0]                                        rf_rdata;
    logic [31:0]                                        csr_rdata;
    logic [commit_pkg::PIPE_WIDTH-1:0]                  flush;
    logic [commit_pkg::PIPE_WIDTH-1:0]                  pause;
    logic [31:0]                                        new_pc;
    logic                                               is_interrupt;
    logic                                               is_llw_scw;

    integer seed;
    int     test_errors;
    int     total_errors;
    int     tests_run;
    int     tests_failed;
    string  test_name;

    commit_top DUT (
        .clk             (clk),
        .rst_i           (rst_i),
        .commit_i        (commit),
        .wb_i            (wb),
        .pause_req_i     (pause_req),
        .branch_flush_i  (branch_flush),
        .branch_target_i (branch_target),
        .ex_excp_flush_i (ex_excp_flush),
        .bpu_flush_i     (bpu_flush),
        .hw_int_i        (hw_int),
        .rf_raddr_i      (rf_raddr),
        .csr_raddr_i     (csr_raddr),
        .rf_rdata_o      (rf_rdata),
        .csr_rdata_o     (csr_rdata),
        .flush_o         (flush),
        .pause_o         (pause),
        .new_pc_o        (new_pc),
        .is_interrupt_o  (is_interrupt),
        .is_llw_scw_o    (is_llw_scw)
    );

    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("ERROR %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, expected);
            test_errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("PASS %s", test_name);
        end else begin
            tests_failed++;
            $display("FAIL %s with %0d errors", test_name, test_errors);
        end
    endtask

    // all slots are bubbles, nothing requested
    task automatic idle_inputs();
        commit        = '0;
        wb            = '0;
        pause_req     = '0;
        branch_flush  = 1'b0;
        branch_target = 32'b0;
        ex_excp_flush = 1'b0;
        bpu_flush     = 1'b0;
    endtask

    task automatic read_csr(input logic [13:0] addr, output logic [31:0] data);
        @(negedge clk);
        csr_raddr = addr;
        #1;
        data = csr_rdata;
    endtask

    task automatic read_reg(input logic [4:0] addr, output logic [31:0] data);
        @(negedge clk);
        rf_raddr = addr;
        #1;
        data = rf_rdata;
    endtask

    task automatic write_csr(input logic [13:0] addr, input logic [31:0] data);
        @(negedge clk);
        idle_inputs();
        wb[0].csr_write_en   = 1'b1;
        wb[0].csr_write_addr = addr;
        wb[0].csr_write_data = data;
        @(negedge clk);
        idle_inputs();
    endtask

    task automatic commit_regs(input logic [4:0] a0, input logic [31:0] d0, input logic en0,
                               input logic [4:0] a1, input logic [31:0] d1, input logic en1);
        @(negedge clk);
        idle_inputs();
        commit[0].pc         = 32'h1c00_0100;
        commit[1].pc         = 32'h1c00_0104;
        wb[0].reg_write_en   = en0;
        wb[0].reg_write_addr = a0;
        wb[0].reg_write_data = d0;
        wb[1].reg_write_en   = en1;
        wb[1].reg_write_addr = a1;
        wb[1].reg_write_data = d1;
        @(negedge clk);
        idle_inputs();
    endtask

    // bits are {if, icache, buffer, decoder, dispatch, execute, mem}
    task automatic pause_case(input string name, input logic [6:0] bits,
                              input logic [7:0] expected);
        @(negedge clk);
        idle_inputs();
        pause_req = commit_pkg::pause_req_t'(bits);
        #1;
        check_value({"pause_o for ", name}, 32'(pause), 32'(expected));
        check_value({"flush_o for ", name}, 32'(flush), 32'h0);
    endtask

    task automatic flush_case(input string name, input logic branch, input logic ex,
                              input logic bpu, input logic [7:0] expected);
        logic [31:0] target;
        target = $random(seed);
        @(negedge clk);
        idle_inputs();
        branch_flush  = branch;
        ex_excp_flush = ex;
        bpu_flush     = bpu;
        branch_target = target;
        #1;
        check_value({"flush_o for ", name}, 32'(flush), 32'(expected));
        check_value({"pause_o for ", name}, 32'(pause), 32'h0);
        if (branch) begin
            check_value("new_pc_o", new_pc, target);
        end
    endtask

    task automatic test_reset_state();
        logic [31:0] rd;
        begin_test("reset_state");
        @(negedge clk);
        idle_inputs();
        #1;
        check_value("flush_o", 32'(flush), 32'h0);
        check_value("pause_o", 32'(pause), 32'h0);
        check_value("is_interrupt_o", 32'(is_interrupt), 32'h0);
        read_csr(commit_pkg::CSR_CRMD, rd);
        check_value("crmd", rd, 32'h0);
        read_csr(commit_pkg::CSR_PRMD, rd);
        check_value("prmd", rd, 32'h0);
        read_csr(commit_pkg::CSR_ESTAT, rd);
        check_value("estat", rd, 32'h0);
        read_csr(commit_pkg::CSR_ERA, rd);
        check_value("era", rd, 32'h0);
        end_test();
    endtask

    task automatic test_reg_commit();
        logic [31:0] d0;
        logic [31:0] d1;
        logic [31:0] d2;
        logic [31:0] d3;
        logic [31:0] rd;
        begin_test("reg_commit");
        d0 = $random(seed);
        d1 = $random(seed);
        d2 = $random(seed);
        d3 = $random(seed);
        commit_regs(5'd5, d0, 1'b1, 5'd6, d1, 1'b1);
        read_reg(5'd5, rd);
        check_value("r5", rd, d0);
        read_reg(5'd6, rd);
        check_value("r6", rd, d1);
        // younger slot should win
        commit_regs(5'd7, d2, 1'b1, 5'd7, d3, 1'b1);
        read_reg(5'd7, rd);
        check_value("r7", rd, d3);
        commit_regs(5'd0, d2, 1'b1, 5'd0, 32'b0, 1'b0);
        read_reg(5'd0, rd);
        check_value("r0", rd, 32'h0);
        // ll/sc flag from either slot is passed out
        @(negedge clk);
        idle_inputs();
        wb[0].is_llw_scw = 1'b1;
        #1;
        check_value("is_llw_scw_o", 32'(is_llw_scw), 32'h1);
        @(negedge clk);
        idle_inputs();
        wb[1].is_llw_scw = 1'b1;
        #1;
        check_value("is_llw_scw_o", 32'(is_llw_scw), 32'h1);
        @(negedge clk);
        idle_inputs();
        #1;
        check_value("is_llw_scw_o", 32'(is_llw_scw), 32'h0);
        end_test();
    endtask

    task automatic test_masks();
        begin_test("pause_flush_masks");
        pause_case("pause_mem",      7'b000_0001, 8'b0111_1000);
        pause_case("pause_execute",  7'b000_0010, 8'b0011_1000);
        pause_case("pause_dispatch", 7'b000_0100, 8'b0001_1000);
        pause_case("pause_decoder",  7'b000_1000, 8'b0000_1000);
        pause_case("pause_buffer",   7'b001_0000, 8'b0000_0111);
        pause_case("pause_icache",   7'b010_0000, 8'b0000_0011);
        pause_case("pause_if",       7'b100_0000, 8'b0000_0001);
        flush_case("branch", 1'b1, 1'b0, 1'b0, 8'b0001_1111);
        flush_case("ex_excp", 1'b0, 1'b1, 1'b0, 8'b0001_1000);
        flush_case("bpu", 1'b0, 1'b0, 1'b1, 8'b0000_0010);
        end_test();
    endtask

    task automatic test_sync_exception();
        logic [31:0] old;
        logic [31:0] rd;
        begin_test("sync_exception");
        old = $random(seed);
        commit_regs(5'd9, old, 1'b1, 5'd0, 32'b0, 1'b0);
        write_csr(commit_pkg::CSR_EENTRY, 32'h1c00_8000);
        write_csr(commit_pkg::CSR_CRMD, 32'h7);
        @(negedge clk);
        idle_inputs();
        // misaligned load flagged in the mem stage
        commit[0].pc                 = 32'h1c00_0200;
        commit[0].is_exception[4]    = 1'b1;
        commit[0].exception_cause[4] = commit_pkg::ALE;
        commit[0].mem_addr           = 32'h0000_1003;
        commit[1].pc                 = 32'h1c00_0204;
        wb[1].reg_write_en           = 1'b1;
        wb[1].reg_write_addr         = 5'd9;
        wb[1].reg_write_data         = ~old;
        #1;
        check_value("new_pc_o", new_pc, 32'h1c00_8000);
        check_value("flush_o", 32'(flush), 32'h7f);
        @(negedge clk);
        idle_inputs();
        read_csr(commit_pkg::CSR_ERA, rd);
        check_value("era", rd, 32'h1c00_0200);
        read_csr(commit_pkg::CSR_ESTAT, rd);
        check_value("estat.ecode", 32'(rd[21:16]), 32'h9);
        read_csr(commit_pkg::CSR_BADV, rd);
        check_value("badv", rd, 32'h0000_1003);
        read_csr(commit_pkg::CSR_CRMD, rd);
        check_value("crmd", rd, 32'h0);
        read_csr(commit_pkg::CSR_PRMD, rd);
        check_value("prmd", rd, 32'h7);
        read_reg(5'd9, rd);
        check_value("r9", rd, old);
        end_test();
    endtask

    task automatic test_return_privilege();
        logic [31:0] rd;
        begin_test("return_privilege");
        @(negedge clk);
        idle_inputs();
        commit[0].pc = 32'h1c00_0300;
        commit[0].op = commit_pkg::OP_ERTN;
        #1;
        check_value("new_pc_o", new_pc, 32'h1c00_0200);
        check_value("flush_o", 32'(flush), 32'h7f);
        @(negedge clk);
        idle_inputs();
        read_csr(commit_pkg::CSR_CRMD, rd);
        check_value("crmd", rd, 32'h7);
        // privileged op seen in decode while at plv 3
        @(negedge clk);
        idle_inputs();
        commit[0].pc                 = 32'h1c00_0400;
        commit[0].is_privilege       = 1'b1;
        commit[0].is_exception[2]    = 1'b1;
        commit[0].exception_cause[2] = commit_pkg::INE;
        @(negedge clk);
        idle_inputs();
        read_csr(commit_pkg::CSR_ESTAT, rd);
        check_value("estat.ecode", 32'(rd[21:16]), 32'he);
        read_csr(commit_pkg::CSR_ERA, rd);
        check_value("era", rd, 32'h1c00_0400);
        end_test();
    endtask

    task automatic test_interrupt();
        logic [31:0] rd;
        begin_test("interrupt");
        write_csr(commit_pkg::CSR_CRMD, 32'h4);
        // hw line 3 maps to enable bit 5
        write_csr(commit_pkg::CSR_ECFG, 32'h20);
        @(negedge clk);
        idle_inputs();
        // bubble pc keeps the idle slot from taking the interrupt
        commit[0].op = commit_pkg::OP_IDLE;
        hw_int       = 8'h08;
        #1;
        check_value("is_interrupt_o", 32'(is_interrupt), 32'h0);
        check_value("pause_o", 32'(pause), 32'h78);
        @(negedge clk);
        #1;
        check_value("is_interrupt_o", 32'(is_interrupt), 32'h1);
        check_value("pause_o", 32'(pause), 32'h0);
        @(negedge clk);
        idle_inputs();
        commit[0].pc = 32'h1c00_0500;
        #1;
        check_value("new_pc_o", new_pc, 32'h1c00_8000);
        @(negedge clk);
        idle_inputs();
        hw_int = 8'h00;
        read_csr(commit_pkg::CSR_ESTAT, rd);
        check_value("estat.ecode", 32'(rd[21:16]), 32'h0);
        read_csr(commit_pkg::CSR_ERA, rd);
        check_value("era", rd, 32'h1c00_0500);
        check_value("is_interrupt_o", 32'(is_interrupt), 32'h0);
        end_test();
    endtask

    initial begin : watchdog
        // six tests at 200 ns each
        #(6 * 200);
        $display("watchdog expired before the tests completed");
        $display("tests failed");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst_i        = 1'b1;
        seed         = 66;
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        hw_int       = 8'h00;
        rf_raddr     = '0;
        csr_raddr    = '0;
        idle_inputs();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;

        test_reset_state();
        test_reg_commit();
        test_masks();
        test_sync_exception();
        test_return_privilege();
        test_interrupt();

        $display("summary: %0d run, %0d failing, %0d check errors",
                 tests_run, tests_failed, total_errors);
        if (tests_failed == 0 && total_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
source/commit_pkg.sv
source/commit_ctrl.sv
source/csr_file.sv
source/arch_regfile.sv
source/commit_top.sv
testbench/commit_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the commit controller testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module commit_tb -f compile.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vcommit_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1
